// ==== compile.f ====
hdl/core_pkg.sv
hdl/stage_if.sv
hdl/fetch_unit.sv
hdl/if_id.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/core_top.sv
test/core_checker.sv
test/tb_core.sv

// ==== hdl/core_pkg.sv ====
package core_pkg;

    // ------------------------------
    // Widths and constants
    // ------------------------------
    localparam int XLEN         = 32;
    localparam int REG_ADDR_W   = 5;
    // 64-word instruction memory
    localparam int IMEM_DEPTH_W = 6;

    // ADDI x0,x0,0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;
    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;

    // ------------------------------
    // Encodings
    // ------------------------------
    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    // Result source
    typedef enum logic {
        WB_ALU,
        WB_PC4
    } wb_sel_e;

    // Decoded controls, 10 bits
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jump;
        logic    reg_write;
        wb_sel_e wb_sel;
    } ctrl_t;

endpackage

// ==== hdl/core_top.sv ====
`timescale 1ns/1ns

module core_top (
    input  logic                             clk,
    input  logic                             i_rst,
    input  logic                             i_run,
    input  logic                             i_imem_we,
    input  logic [core_pkg::IMEM_DEPTH_W-1:0] i_imem_addr,
    input  logic [core_pkg::XLEN-1:0]         i_imem_data,
    output logic                             o_ret_valid,
    output logic [core_pkg::XLEN-1:0]         o_ret_pc,
    output logic [core_pkg::REG_ADDR_W-1:0]   o_ret_rd,
    output logic [core_pkg::XLEN-1:0]         o_ret_data
);
    import core_pkg::*;

    // Fetch side
    logic [XLEN-1:0]       pc_if;
    logic [XLEN-1:0]       pc_plus4_if;
    logic [XLEN-1:0]       instr_if;
    logic [XLEN-1:0]       pc_id;
    logic [XLEN-1:0]       pc_plus4_id;
    logic [XLEN-1:0]       instr_id;
    // Redirect from execute
    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;
    // Register file write
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    dec_ex_if u_dec_ex ();
    ex_res_if u_ex_res ();

    fetch_unit u_fetch (
        .clk(clk), .i_rst(i_rst), .i_run(i_run),
        .i_redirect(redirect), .i_redirect_pc(redirect_pc),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_pc(pc_if), .o_pc_plus4(pc_plus4_if), .o_instr(instr_if)
    );

    // Holds while stopped
    if_id u_if_id (
        .clk(clk), .i_rst(i_rst), .i_flush_id(redirect), .i_stall_id(!i_run),
        .i_pc_if(pc_if), .i_pc_plus4_if(pc_plus4_if), .i_instr_if(instr_if),
        .o_pc_id(pc_id), .o_pc_plus4_id(pc_plus4_id), .o_instr_id(instr_id)
    );

    decode_stage u_decode (
        .clk(clk), .i_rst(i_rst), .i_flush(redirect), .i_hold(!i_run),
        .i_pc(pc_id), .i_pc_plus4(pc_plus4_id), .i_instr(instr_id),
        .i_wb_en(wb_en), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
        .dec_ex(u_dec_ex.dec)
    );

    execute_stage u_execute (
        .clk(clk), .i_rst(i_rst),
        .dec_ex(u_dec_ex.ex), .ex_res(u_ex_res.ex),
        .o_redirect(redirect), .o_redirect_pc(redirect_pc)
    );

    result_stage u_result (
        .ex_res(u_ex_res.res),
        .o_wb_en(wb_en), .o_wb_rd(wb_rd), .o_wb_data(wb_data),
        .o_ret_valid(o_ret_valid), .o_ret_pc(o_ret_pc),
        .o_ret_rd(o_ret_rd), .o_ret_data(o_ret_data)
    );

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic                           i_flush,
    input  logic                           i_hold,
    input  logic [core_pkg::XLEN-1:0]       i_pc,
    input  logic [core_pkg::XLEN-1:0]       i_pc_plus4,
    input  logic [core_pkg::XLEN-1:0]       i_instr,
    input  logic                           i_wb_en,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input  logic [core_pkg::XLEN-1:0]       i_wb_data,
    dec_ex_if.dec                          dec_ex
);
    import core_pkg::*;

    // x1..x31 only, x0 is hardwired
    logic [XLEN-1:0]       regs [1:31];
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rs1_idx;
    logic [REG_ADDR_W-1:0] rs2_idx;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic [XLEN-1:0]       imm;
    ctrl_t                 ctrl;

    // ALU op from funct3, sub only from OP with bit 30
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b111:  return ALU_AND;
            3'b110:  return ALU_OR;
            3'b100:  return ALU_XOR;
            3'b010:  return ALU_SLT;
            3'b001:  return ALU_SLL;
            3'b101:  return ALU_SRL;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opcode  = opcode_e'(i_instr[6:0]);
    assign funct3  = i_instr[14:12];
    assign rs1_idx = i_instr[19:15];
    assign rs2_idx = i_instr[24:20];

    // ------------------------------
    // Register file
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_wb_en) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // Same-cycle write passes straight through
    assign rs1_val = (rs1_idx == '0) ? '0 :
                     (i_wb_en && i_wb_rd == rs1_idx) ? i_wb_data : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 :
                     (i_wb_en && i_wb_rd == rs2_idx) ? i_wb_data : regs[rs2_idx];

    // ------------------------------
    // Decoder and immediates
    // ------------------------------
    always_comb begin
        // Unknown opcodes decode as a no-op
        ctrl = '0;
        imm  = '0;
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op    = alu_sel(funct3, i_instr[30]);
                ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op    = alu_sel(funct3, 1'b0);
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm = {{20{i_instr[31]}}, i_instr[31:20]};
            end
            OPC_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm = {i_instr[31:12], 12'b0};
            end
            OPC_JAL: begin
                ctrl.is_jump   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                       i_instr[20], i_instr[30:21], 1'b0};
            end
            OPC_BRANCH: begin
                // BEQ is funct3 000, BNE is 001
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = funct3[0];
                imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                       i_instr[30:25], i_instr[11:8], 1'b0};
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // ------------------------------
    // Decode to execute register
    // ------------------------------
    always_ff @(posedge clk) begin
        // Bubble on flush or while stopped
        if (i_rst) begin
            dec_ex.valid <= 1'b0;
        end else begin
            dec_ex.valid <= !(i_flush || i_hold);
        end
        dec_ex.pc       <= i_pc;
        dec_ex.pc_plus4 <= i_pc_plus4;
        dec_ex.rs1_val  <= rs1_val;
        dec_ex.rs2_val  <= rs2_val;
        dec_ex.rs1_idx  <= rs1_idx;
        dec_ex.rs2_idx  <= rs2_idx;
        dec_ex.imm      <= imm;
        dec_ex.rd       <= i_instr[11:7];
        dec_ex.ctrl     <= ctrl;
    end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
    input  logic                     clk,
    input  logic                     i_rst,
    dec_ex_if.ex                     dec_ex,
    ex_res_if.ex                     ex_res,
    output logic                     o_redirect,
    output logic [core_pkg::XLEN-1:0] o_redirect_pc
);
    import core_pkg::*;

    logic            fwd_ok;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic            taken;

    // ------------------------------
    // Forwarding
    // ------------------------------
    // Result stage entry that really writes a register
    assign fwd_ok = ex_res.valid && ex_res.reg_write && (ex_res.rd != '0);

    assign op_a    = (fwd_ok && ex_res.rd == dec_ex.rs1_idx) ? ex_res.data
                                                              : dec_ex.rs1_val;
    assign rs2_fwd = (fwd_ok && ex_res.rd == dec_ex.rs2_idx) ? ex_res.data
                                                              : dec_ex.rs2_val;
    // Immediate select
    assign op_b    = dec_ex.ctrl.use_imm ? dec_ex.imm : rs2_fwd;

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (dec_ex.ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            // Shift amount is the low five bits
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // ------------------------------
    // Branch and jump resolution
    // ------------------------------
    // BEQ taken on equal, BNE on not equal
    assign taken = dec_ex.ctrl.is_jump ||
                   (dec_ex.ctrl.is_branch && ((op_a == rs2_fwd) != dec_ex.ctrl.branch_ne));

    // One-cycle pulse, only for a live entry
    assign o_redirect    = dec_ex.valid && taken;
    // Both JAL and branches are PC relative
    assign o_redirect_pc = dec_ex.pc + dec_ex.imm;

    // Execute to result register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            ex_res.valid     <= 1'b0;
            ex_res.reg_write <= 1'b0;
        end else begin
            ex_res.valid     <= dec_ex.valid;
            ex_res.reg_write <= dec_ex.ctrl.reg_write;
        end
        ex_res.rd   <= dec_ex.rd;
        ex_res.pc   <= dec_ex.pc;
        // JAL writes its link address
        ex_res.data <= (dec_ex.ctrl.wb_sel == WB_PC4) ? dec_ex.pc_plus4 : alu_res;
    end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
    input  logic                             clk,
    input  logic                             i_rst,
    input  logic                             i_run,
    input  logic                             i_redirect,
    input  logic [core_pkg::XLEN-1:0]         i_redirect_pc,
    input  logic                             i_imem_we,
    input  logic [core_pkg::IMEM_DEPTH_W-1:0] i_imem_addr,
    input  logic [core_pkg::XLEN-1:0]         i_imem_data,
    output logic [core_pkg::XLEN-1:0]         o_pc,
    output logic [core_pkg::XLEN-1:0]         o_pc_plus4,
    output logic [core_pkg::XLEN-1:0]         o_instr
);
    import core_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4;
    // Word array, filled through the load port
    logic [XLEN-1:0] imem [0:(1<<IMEM_DEPTH_W)-1];

    assign pc_plus4 = pc_q + 32'd4;

    // ------------------------------
    // PC register
    // ------------------------------
    // Redirect wins over run so a flush while stopped still lands
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc_q <= RESET_PC;
        end else if (i_redirect) begin
            pc_q <= i_redirect_pc;
        end else if (i_run) begin
            pc_q <= pc_plus4;
        end
    end

    // Load port
    always_ff @(posedge clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // Asynchronous read, word addressed
    assign o_instr    = imem[pc_q[IMEM_DEPTH_W+1:2]];
    assign o_pc       = pc_q;
    assign o_pc_plus4 = pc_plus4;

endmodule

// ==== hdl/if_id.sv ====
`timescale 1ns/1ns

module if_id (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_flush_id,
    input  logic                     i_stall_id,
    input  logic [core_pkg::XLEN-1:0] i_pc_if,
    input  logic [core_pkg::XLEN-1:0] i_pc_plus4_if,
    input  logic [core_pkg::XLEN-1:0] i_instr_if,
    output logic [core_pkg::XLEN-1:0] o_pc_id,
    output logic [core_pkg::XLEN-1:0] o_pc_plus4_id,
    output logic [core_pkg::XLEN-1:0] o_instr_id
);
    import core_pkg::*;

    // Reset behaves like a flush
    // Flush has priority over stall
    always_ff @(posedge clk) begin
        if (i_rst || i_flush_id) begin
            o_pc_id       <= '0;
            o_pc_plus4_id <= 32'd4;
            // Bubble into decode
            o_instr_id    <= NOP_INSTR;
        end else if (!i_stall_id) begin
            o_pc_id       <= i_pc_if;
            o_pc_plus4_id <= i_pc_plus4_if;
            o_instr_id    <= i_instr_if;
        end
    end

endmodule

// ==== hdl/result_stage.sv ====
`timescale 1ns/1ns

module result_stage (
    ex_res_if.res                          ex_res,
    output logic                           o_wb_en,
    output logic [core_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [core_pkg::XLEN-1:0]       o_wb_data,
    output logic                           o_ret_valid,
    output logic [core_pkg::XLEN-1:0]       o_ret_pc,
    output logic [core_pkg::REG_ADDR_W-1:0] o_ret_rd,
    output logic [core_pkg::XLEN-1:0]       o_ret_data
);
    import core_pkg::*;

    logic wb_en;

    // Write only for live entries that target x1..x31
    assign wb_en = ex_res.valid && ex_res.reg_write && (ex_res.rd != '0);

    // ------------------------------
    // Register file write port
    // ------------------------------
    assign o_wb_en   = wb_en;
    assign o_wb_rd   = ex_res.rd;
    assign o_wb_data = ex_res.data;

    // Retire mirrors the write in the same cycle
    assign o_ret_valid = wb_en;
    assign o_ret_pc    = ex_res.pc;
    assign o_ret_rd    = ex_res.rd;
    assign o_ret_data  = ex_res.data;

endmodule

// ==== hdl/stage_if.sv ====
`timescale 1ns/1ns

// Decode to execute bundle
interface dec_ex_if;
    import core_pkg::*;

    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       pc_plus4;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic [REG_ADDR_W-1:0] rs1_idx;
    logic [REG_ADDR_W-1:0] rs2_idx;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    ctrl_t                 ctrl;

    modport dec (output valid, pc, pc_plus4, rs1_val, rs2_val,
                 rs1_idx, rs2_idx, imm, rd, ctrl);
    modport ex  (input  valid, pc, pc_plus4, rs1_val, rs2_val,
                 rs1_idx, rs2_idx, imm, rd, ctrl);
endinterface

// Execute to result bundle
interface ex_res_if;
    import core_pkg::*;

    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    logic [XLEN-1:0]       data;
    logic [XLEN-1:0]       pc;

    // Execute also reads these back for forwarding
    modport ex  (output valid, rd, reg_write, data, pc);
    modport res (input  valid, rd, reg_write, data, pc);
endinterface

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_core -f compile.f -o tb_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// ==== test/core_checker.sv ====
`timescale 1ns/1ns

module core_checker (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic                           i_ret_valid,
    input  logic [core_pkg::XLEN-1:0]       i_ret_pc,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_ret_rd,
    input  logic [core_pkg::XLEN-1:0]       i_ret_data
);
    import core_pkg::*;

    // Expected register writes, oldest first
    logic [XLEN-1:0]       exp_pc [$];
    logic [REG_ADDR_W-1:0] exp_rd [$];
    logic [XLEN-1:0]       exp_data [$];
    int                    checks = 0;
    int                    errors = 0;

    // ------------------------------
    // Queue access for the testbench
    // ------------------------------
    function void expect_write(input logic [XLEN-1:0] pc, input logic [REG_ADDR_W-1:0] rd,
                               input logic [XLEN-1:0] data);
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endfunction

    function int pending();
        return exp_pc.size();
    endfunction

    // Drops leftovers of an aborted test
    function void clear();
        exp_pc.delete();
        exp_rd.delete();
        exp_data.delete();
    endfunction

    function void compare(input string name, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h expected %h", name, got, exp);
        end
    endfunction

    // ------------------------------
    // Retire monitor
    // ------------------------------
    // Sampled mid-cycle, retire ports only move on the rising edge
    always @(negedge clk) begin
        if (!i_rst && i_ret_valid) begin
            checks++;
            if (i_ret_rd == '0) begin
                errors++;
                $display("ERR o_ret_rd: got %h at pc %h, x0 must never retire",
                         i_ret_rd, i_ret_pc);
            end else if (exp_pc.size() == 0) begin
                errors++;
                $display("unexpected retire at pc %h when no write was left to expect",
                         i_ret_pc);
            end else begin
                compare("o_ret_pc", i_ret_pc, exp_pc.pop_front());
                compare("o_ret_rd", {27'b0, i_ret_rd}, {27'b0, exp_rd.pop_front()});
                compare("o_ret_data", i_ret_data, exp_data.pop_front());
            end
        end
    end

endmodule

// ==== test/tb_core.sv ====
`timescale 1ns/1ns

module tb_core;
    import core_pkg::*;

    localparam int TIMEOUT_CYC = 2000;

    logic                    clk;
    logic                    i_rst;
    logic                    i_run;
    logic                    i_imem_we;
    logic [IMEM_DEPTH_W-1:0] i_imem_addr;
    logic [XLEN-1:0]         i_imem_data;
    logic                    o_ret_valid;
    logic [XLEN-1:0]         o_ret_pc;
    logic [REG_ADDR_W-1:0]   o_ret_rd;
    logic [XLEN-1:0]         o_ret_data;

    // Program image, mirrored into the DUT memory
    logic [XLEN-1:0] prog [0:(1<<IMEM_DEPTH_W)-1];
    int              prog_len = 0;
    logic [31:0]     rng = 32'h04a37225;
    // Supported funct3 values of OP and OP-IMM
    int              f3_tab [0:6] = '{0, 1, 2, 4, 5, 6, 7};
    int              tests_run = 0;
    int              tests_failed = 0;

    core_top i_dut (
        .clk(clk), .i_rst(i_rst), .i_run(i_run),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_ret_valid(o_ret_valid), .o_ret_pc(o_ret_pc),
        .o_ret_rd(o_ret_rd), .o_ret_data(o_ret_data)
    );

    core_checker u_chk (
        .clk(clk), .i_rst(i_rst), .i_ret_valid(o_ret_valid), .i_ret_pc(o_ret_pc),
        .i_ret_rd(o_ret_rd), .i_ret_data(o_ret_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // Random numbers and encoders
    // ------------------------------
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng = x;
        return x;
    endfunction

    function automatic int pick(input int n);
        return int'(next_rand() % n);
    endfunction

    function automatic logic [31:0] alu_rr(input int f3, input logic sub,
                                           input int rd, input int rs1, input int rs2);
        return {1'b0, sub, 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] alu_ri(input int f3, input int rd, input int rs1,
                                           input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] lui(input int rd, input int hi);
        return {hi[19:0], rd[4:0], 7'b0110111};
    endfunction

    // Offsets in bytes from the instruction's own pc
    function automatic logic [31:0] jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] branch(input logic ne, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 2'b00, ne, off[4:1], off[11],
                7'b1100011};
    endfunction

    // ------------------------------
    // Program building
    // ------------------------------
    function automatic void emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    // Random OP or OP-IMM instruction, SUB only in the register form
    function automatic logic [31:0] rand_alu(input int rd, input int rs1, input int rs2);
        int f3;
        int imm;
        f3  = f3_tab[pick(7)];
        imm = pick(4096) - 2048;
        if (pick(2) == 0) begin
            return alu_rr(f3, f3 == 0 && pick(2) == 1, rd, rs1, rs2);
        end
        // Shifts take a 5-bit shamt
        if (f3 == 1 || f3 == 5) begin
            imm = pick(32);
        end
        return alu_ri(f3, rd, rs1, imm);
    endfunction

    // LUI then ADDI gives x1..x7 random values before any read
    function automatic void init_regs();
        for (int r = 1; r <= 7; r++) begin
            emit(lui(r, pick(1 << 20)));
            emit(alu_ri(0, r, r, pick(4096)));
        end
    endfunction

    // Each op reads the previous result and one from two or three back
    function automatic void dep_chain(input int n);
        int d1;
        int d2;
        int d3;
        int rd;
        d1 = 7;
        d2 = 6;
        d3 = 5;
        for (int i = 0; i < n; i++) begin
            rd = 1 + pick(7);
            emit(rand_alu(rd, d1, (pick(2) == 0) ? d2 : d3));
            d3 = d2;
            d2 = d1;
            d1 = rd;
        end
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    // Runs prog from RESET_PC up to the jump onto itself
    function automatic int model_run();
        logic [31:0] x [0:31];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic        wr;
        int          n;
        n  = 0;
        pc = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        for (int step = 0; step < 400; step++) begin
            ins     = prog[pc[IMEM_DEPTH_W+1:2]];
            rd      = ins[11:7];
            a       = x[ins[19:15]];
            // Register operand for OP, I immediate otherwise
            b       = (ins[6:0] == 7'b0110011) ? x[ins[24:20]]
                                               : {{20{ins[31]}}, ins[31:20]};
            res     = '0;
            wr      = 1'b1;
            next_pc = pc + 4;
            case (ins[6:0])
                7'b0110011, 7'b0010011: begin
                    case (ins[14:12])
                        3'd0: res = (ins[5] && ins[30]) ? a - b : a + b;
                        3'd1: res = a << b[4:0];
                        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd4: res = a ^ b;
                        3'd5: res = a >> b[4:0];
                        3'd6: res = a | b;
                        3'd7: res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                7'b0110111: res = {ins[31:12], 12'b0};
                7'b1101111: begin
                    res     = pc + 4;
                    next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'b1100011: begin
                    wr = 1'b0;
                    // funct3 bit 0 turns BEQ into BNE
                    if ((a == x[ins[24:20]]) != ins[12]) begin
                        next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != 0) begin
                x[rd] = res;
                u_chk.expect_write(pc, rd, res);
                n++;
            end
            if (next_pc == pc) begin
                break;
            end
            pc = next_pc;
        end
        return n;
    endfunction

    // ------------------------------
    // Test sequencing
    // ------------------------------
    task automatic load_program();
        for (int a = 0; a < (1 << IMEM_DEPTH_W); a++) begin
            // Unused words hold an ADDI x0 carrying their own address
            if (a >= prog_len) begin
                prog[a] = alu_ri(0, 0, 0, a);
            end
            @(negedge clk);
            i_imem_we   = 1'b1;
            i_imem_addr = a[IMEM_DEPTH_W-1:0];
            i_imem_data = prog[a];
        end
        @(negedge clk);
        i_imem_we = 1'b0;
    endtask

    task automatic run_test(input string name, input bit pause);
        int cycles;
        int errs_before;
        int expected;
        cycles      = 0;
        errs_before = u_chk.errors;
        load_program();
        expected = model_run();
        @(negedge clk);
        i_run = 1'b1;
        while (u_chk.pending() != 0 && cycles < TIMEOUT_CYC) begin
            @(negedge clk);
            cycles++;
            // Fetch stops for three of every nine cycles
            if (pause) begin
                i_run = (cycles % 9) < 6;
            end
        end
        // Let stray wrong-path writes show up before stopping
        i_run = 1'b1;
        repeat (8) @(negedge clk);
        i_run = 1'b0;
        i_rst = 1'b1;
        repeat (2) @(negedge clk);
        i_rst = 1'b0;
        tests_run++;
        if (u_chk.pending() != 0) begin
            $display("test %s: timed out with %0d of %0d writes not retired",
                     name, u_chk.pending(), expected);
            u_chk.clear();
            tests_failed++;
        end else if (u_chk.errors != errs_before) begin
            $display("test %s: FAIL, %0d errors", name, u_chk.errors - errs_before);
            tests_failed++;
        end else begin
            $display("test %s: PASS, %0d writes retired", name, expected);
        end
    endtask

    initial begin
        i_rst       = 1'b1;
        i_run       = 1'b0;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        repeat (16) @(negedge clk);
        i_rst = 1'b0;

        // Straight line of random ALU ops
        prog_len = 0;
        init_regs();
        for (int i = 0; i < 30; i++) begin
            emit(rand_alu(1 + pick(7), pick(8), pick(8)));
        end
        emit(jal(0, 0));
        run_test("alu_random", 1'b0);

        // Back-to-back dependencies
        prog_len = 0;
        init_regs();
        dep_chain(24);
        emit(jal(0, 0));
        run_test("dependent", 1'b0);

        // Branches and JAL, wrong-path writes must not retire
        prog_len = 0;
        emit(alu_ri(0, 1, 0, 5));
        emit(alu_ri(0, 2, 0, 5));
        emit(alu_ri(0, 3, 0, 7));
        emit(branch(1'b0, 1, 2, 12));
        emit(alu_ri(0, 4, 0, 1));
        emit(alu_ri(0, 5, 0, 2));
        emit(branch(1'b1, 1, 2, 8));
        emit(alu_ri(0, 6, 0, 3));
        emit(branch(1'b1, 1, 3, 12));
        emit(alu_ri(0, 7, 0, 4));
        emit(alu_ri(0, 8, 0, 5));
        emit(branch(1'b0, 1, 3, 8));
        emit(jal(9, 12));
        emit(alu_ri(0, 10, 0, 6));
        emit(alu_ri(0, 11, 0, 7));
        // Link value used right away
        emit(alu_rr(0, 1'b0, 12, 9, 1));
        // Countdown loop, three passes
        emit(alu_ri(0, 13, 0, 3));
        emit(alu_ri(0, 13, 13, -1));
        emit(branch(1'b1, 13, 0, -4));
        emit(jal(0, 0));
        run_test("branch_jump", 1'b0);

        // LUI and writes to x0
        prog_len = 0;
        emit(lui(1, pick(1 << 20)));
        emit(lui(0, pick(1 << 20)));
        emit(alu_ri(0, 0, 0, 123));
        emit(alu_rr(0, 1'b0, 2, 0, 1));
        emit(alu_ri(0, 0, 1, 5));
        emit(alu_rr(6, 1'b0, 3, 0, 0));
        emit(alu_rr(0, 1'b1, 4, 1, 0));
        emit(jal(0, 8));
        emit(alu_ri(0, 5, 0, 9));
        emit(lui(6, pick(1 << 20)));
        emit(alu_ri(0, 7, 6, pick(4096)));
        emit(alu_rr(4, 1'b0, 8, 0, 7));
        emit(jal(0, 0));
        run_test("lui_x0", 1'b0);

        // Same kind of code with fetch paused now and then
        prog_len = 0;
        init_regs();
        dep_chain(12);
        emit(alu_ri(0, 13, 0, 4));
        emit(alu_ri(0, 13, 13, -1));
        emit(branch(1'b1, 13, 0, -4));
        emit(jal(9, 8));
        emit(alu_ri(0, 10, 0, 6));
        emit(alu_rr(0, 1'b0, 12, 9, 13));
        emit(jal(0, 0));
        run_test("run_pause", 1'b1);

        $display("%0d tests run, %0d failed, %0d retires seen, %0d errors",
                 tests_run, tests_failed, u_chk.checks, u_chk.errors);
        if (tests_failed == 0 && u_chk.errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
